// ==== verilog/eth_tx_defines.svh ====
`ifndef ETH_TX_DEFINES_SVH
`define ETH_TX_DEFINES_SVH

// Store-and-forward buffer size in bytes
// Must be a power of two so the pointers wrap on their own
// A frame longer than this can never become whole in the buffer
`define ETH_TX_FIFO_DEPTH 128

// Bytes from destination address through pad, FCS not included
// 6 DA + 6 SA + 2 type + 46 payload
`define ETH_MIN_FRAME 60

// Count of 0x55 bytes ahead of the SFD
`define ETH_PREAMBLE_LEN 7

// Idle cycles after the last FCS byte
// 96 bit times at one byte per cycle
`define ETH_IFG_LEN 12

`endif

// ==== verilog/eth_tx_pkg.sv ====
`default_nettype none

`include "eth_tx_defines.svh"

package eth_tx_pkg;

    typedef logic [7:0]  byte_t;                  // One frame byte on the stream or the wire
    typedef logic [31:0] crc_t;                   // CRC-32 register or FCS value

    // Frame or byte count, one bit wider than needed to hold the buffer depth
    typedef logic [$clog2(`ETH_TX_FIFO_DEPTH + 1)-1:0] frame_cnt_t;

    // Stream beat, same shape on the host side and the MAC side of the buffer
    typedef struct packed {
        byte_t data;                              // Frame byte, DA first
        logic  last;                              // Final byte of the frame
    } fifo_entry_t;

    // GMII-style byte output toward the PHY
    typedef struct packed {
        byte_t data;                              // TXD
        logic  en;                                // TX_EN
    } gmii_tx_t;

    // Transmit FSM, each state names what gets loaded into tx next
    typedef enum logic [2:0] {
        IDLE,                                     // Waiting for a whole frame
        PREAMBLE,                                 // 0x55 bytes
        SFD,                                      // Single 0xD5
        DATA,                                     // Bytes from the buffer
        PAD,                                      // Zero fill up to minimum length
        FCS,                                      // Four CRC bytes, low byte first
        IFG                                       // Inter-frame gap, tx.en low
    } tx_state_t;

endpackage

`default_nettype wire

// ==== verilog/eth_tx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_defines.svh"

module eth_tx_fifo (
    input  wire                      clk,
    input  wire                      reset_n,
    input  eth_tx_pkg::fifo_entry_t  s_beat,        // Host beat
    input  wire                      s_valid,       // Host has a beat
    output logic                     s_ready,       // Room for one more beat
    input  wire                      rd_en,         // MAC consumes rd_beat
    output eth_tx_pkg::fifo_entry_t  rd_beat,       // Head of buffer, show-ahead
    output logic                     frame_avail    // At least one whole frame stored
);

    import eth_tx_pkg::*;

    localparam int PTR_W = $clog2(`ETH_TX_FIFO_DEPTH);                  // Pointer width
    localparam frame_cnt_t DEPTH_CNT = frame_cnt_t'(`ETH_TX_FIFO_DEPTH); // Full level

    fifo_entry_t      mem [`ETH_TX_FIFO_DEPTH];     // Byte storage, no reset
    logic [PTR_W-1:0] wr_ptr;                       // Next slot to write
    logic [PTR_W-1:0] rd_ptr;                       // Current head slot
    frame_cnt_t       count;                        // Beats stored
    frame_cnt_t       frame_cnt;                    // Frames with last beat stored
    logic             wr;                           // Host beat accepted this cycle
    logic             rd;                           // MAC beat taken this cycle

    assign wr = s_valid && s_ready;
    assign rd = rd_en;                              // MAC only reads inside a whole frame

    assign s_ready     = (count != DEPTH_CNT);      // Low only when full
    assign frame_avail = (frame_cnt != '0);
    assign rd_beat     = mem[rd_ptr];               // Head is visible without a read

    // Storage array
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= s_beat;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;            // Wraps at depth, power of two
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Both or neither, level unchanged
            endcase
        end
    end

    // Whole-frame counter, up on a stored last beat, down on a consumed one
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            frame_cnt <= '0;
        end else begin
            case ({wr && s_beat.last, rd && rd_beat.last})
                2'b10:   frame_cnt <= frame_cnt + 1'b1;
                2'b01:   frame_cnt <= frame_cnt - 1'b1;
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eth_crc32.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
    input  wire               clk,
    input  wire               reset_n,
    input  wire               crc_clear,        // Preset to all ones for a new frame
    input  wire               crc_en,           // Fold crc_data in this cycle
    input  eth_tx_pkg::byte_t crc_data,         // Byte to fold, LSB first on the wire
    output eth_tx_pkg::crc_t  crc               // Inverted register, ready as FCS
);

    import eth_tx_pkg::*;

    // 0x04C11DB7 bit-reversed, since Ethernet shifts LSB first
    localparam crc_t POLY_REFL = 32'hEDB8_8320;

    crc_t crc_reg;                              // Running remainder
    crc_t crc_next;                             // Remainder after this byte

    // One byte, eight shift steps
    always_comb begin
        crc_next = crc_reg ^ {24'h00_0000, crc_data};
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ POLY_REFL;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            crc_reg <= '1;
        end else if (crc_clear) begin
            crc_reg <= '1;                      // Clear wins over enable
        end else if (crc_en) begin
            crc_reg <= crc_next;
        end
    end

    // Final XOR. Byte 0 goes out first
    assign crc = ~crc_reg;

endmodule

`default_nettype wire

// ==== verilog/eth_tx_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_defines.svh"

module eth_tx_mac (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      frame_avail,   // Whole frame waiting in buffer
    input  eth_tx_pkg::fifo_entry_t  rd_beat,       // Buffer head, show-ahead
    output logic                     rd_en,         // Take rd_beat this cycle
    input  wire                      phy_ready,     // PHY accepts a byte this cycle
    output logic                     crc_clear,     // Start a new CRC
    output logic                     crc_en,        // Fold crc_data into CRC
    output eth_tx_pkg::byte_t        crc_data,      // Byte folded into CRC
    input  eth_tx_pkg::crc_t         crc,           // FCS, inverted already
    output eth_tx_pkg::gmii_tx_t     tx             // Registered PHY output
);

    import eth_tx_pkg::*;

    localparam byte_t PRE_BYTE = 8'h55;             // Preamble pattern
    localparam byte_t SFD_BYTE = 8'hD5;             // Start of frame delimiter
    localparam byte_t PAD_BYTE = 8'h00;

    localparam frame_cnt_t PRE_LAST = frame_cnt_t'(`ETH_PREAMBLE_LEN - 1);
    localparam frame_cnt_t IFG_LAST = frame_cnt_t'(`ETH_IFG_LEN - 1);
    localparam frame_cnt_t MIN_LEN  = frame_cnt_t'(`ETH_MIN_FRAME);
    localparam frame_cnt_t FCS_LAST = frame_cnt_t'(3);  // Four FCS bytes

    tx_state_t  state;                              // What is loaded into tx next
    frame_cnt_t byte_cnt;                           // Position in preamble, FCS or gap
    frame_cnt_t len_cnt;                            // Frame bytes loaded so far, pad included
    frame_cnt_t len_next;                           // len_cnt counting the byte loaded now
    byte_t      fcs_byte;                           // FCS byte picked by byte_cnt

    assign len_next = len_cnt + 1'b1;
    assign fcs_byte = crc[{byte_cnt[1:0], 3'b000} +: 8];

    // Buffer and CRC side, all tied to a PHY-ready cycle
    assign rd_en     = phy_ready && (state == DATA);
    assign crc_clear = phy_ready && (state == IDLE) && frame_avail;
    assign crc_en    = phy_ready && ((state == DATA) || (state == PAD));
    assign crc_data  = (state == DATA) ? rd_beat.data : PAD_BYTE;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= IDLE;
            byte_cnt <= '0;
            len_cnt  <= '0;
            tx       <= '0;                         // tx.en low out of reset
        end else if (phy_ready) begin              // Everything holds while PHY stalls
            case (state)
                IDLE: begin
                    tx <= '0;
                    if (frame_avail) begin          // Only whole frames start
                        byte_cnt <= '0;
                        len_cnt  <= '0;
                        state    <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    tx.data <= PRE_BYTE;
                    tx.en   <= 1'b1;
                    if (byte_cnt == PRE_LAST) begin
                        byte_cnt <= '0;
                        state    <= SFD;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                SFD: begin
                    tx.data <= SFD_BYTE;
                    tx.en   <= 1'b1;
                    state   <= DATA;
                end
                DATA: begin
                    tx.data <= rd_beat.data;        // Same byte goes into the CRC
                    tx.en   <= 1'b1;
                    len_cnt <= len_next;
                    if (rd_beat.last) begin
                        if (len_next >= MIN_LEN) begin
                            state <= FCS;           // Long enough, no pad
                        end else begin
                            state <= PAD;
                        end
                    end
                end
                PAD: begin
                    tx.data <= PAD_BYTE;
                    tx.en   <= 1'b1;
                    len_cnt <= len_next;
                    if (len_next == MIN_LEN) begin
                        state <= FCS;
                    end
                end
                FCS: begin
                    // CRC settled on the edge that left DATA or PAD
                    tx.data <= fcs_byte;
                    tx.en   <= 1'b1;
                    if (byte_cnt == FCS_LAST) begin
                        byte_cnt <= '0;
                        state    <= IFG;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                IFG: begin
                    tx <= '0;                       // Gap, the IDLE pass adds one more
                    if (byte_cnt == IFG_LAST) begin
                        byte_cnt <= '0;
                        state    <= IDLE;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: begin
                    tx    <= '0;
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eth_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_tx_top (
    input  wire                      clk,
    input  wire                      reset_n,
    input  eth_tx_pkg::fifo_entry_t  s_beat,        // Host stream beat
    input  wire                      s_valid,
    output logic                     s_ready,
    input  wire                      phy_ready,     // PHY back-pressure
    output eth_tx_pkg::gmii_tx_t     tx             // Byte-wide PHY output
);

    import eth_tx_pkg::*;

    fifo_entry_t rd_beat;                           // Buffer head to MAC
    logic        frame_avail;                       // Whole frame ready
    logic        rd_en;                             // MAC pops a beat
    logic        crc_clear;
    logic        crc_en;
    byte_t       crc_data;
    crc_t        crc;                               // FCS back to MAC

    // Store-and-forward buffer, MAC never sees a partial frame
    eth_tx_fifo eth_tx_fifo_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .s_beat      (s_beat),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .rd_en       (rd_en),
        .rd_beat     (rd_beat),
        .frame_avail (frame_avail)
    );

    eth_tx_mac eth_tx_mac_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_avail (frame_avail),
        .rd_beat     (rd_beat),
        .rd_en       (rd_en),
        .phy_ready   (phy_ready),
        .crc_clear   (crc_clear),
        .crc_en      (crc_en),
        .crc_data    (crc_data),
        .crc         (crc),
        .tx          (tx)
    );

    // FCS generator, covers data and pad bytes
    eth_crc32 eth_crc32_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .crc_clear   (crc_clear),
        .crc_en      (crc_en),
        .crc_data    (crc_data),
        .crc         (crc)
    );

endmodule

`default_nettype wire

// ==== dv/eth_tx_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_tx_props (
    input wire                      clk,
    input wire                      reset_n,
    input eth_tx_pkg::fifo_entry_t  s_beat,
    input wire                      s_valid,
    input wire                      s_ready,
    input wire                      phy_ready,
    input eth_tx_pkg::gmii_tx_t     tx
);

    // No transmit straight out of reset
    idle_after_reset: assert property (@(posedge clk) !reset_n |=> !tx.en)
        else $error("tx.en high in the cycle after reset");

    // PHY stall freezes the output byte and enable
    tx_hold_on_stall: assert property (@(posedge clk) disable iff (!reset_n)
        !phy_ready |=> $stable(tx))
        else $error("tx changed while phy_ready was low");

    // Host keeps its beat until the buffer takes it
    beat_hold_on_full: assert property (@(posedge clk) disable iff (!reset_n)
        s_valid && !s_ready |=> $stable(s_beat))
        else $error("s_beat changed while waiting for s_ready");

endmodule

bind eth_tx_top eth_tx_props eth_tx_props_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .s_beat    (s_beat),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .phy_ready (phy_ready),
    .tx        (tx)
);

`default_nettype wire

// ==== dv/eth_tx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_defines.svh"

module eth_tx_tb;

    import eth_tx_pkg::*;

    typedef byte_t byte_q_t[$];

    localparam int CLK_PERIOD = 20;
    localparam int NUM_FRAMES = 9;
    localparam int FRAME_LEN [NUM_FRAMES] = '{20, 100, 30, 64, 45, 50, 75, 120, 70};
    localparam frame_cnt_t IFG_MIN = frame_cnt_t'(`ETH_IFG_LEN);

    logic        clk;
    logic        reset_n;
    fifo_entry_t s_beat;
    logic        s_valid;
    logic        s_ready;
    logic        phy_ready;
    gmii_tx_t    tx;

    logic        stall_on;                          // Random PHY stalls enabled
    int          gap_pct;                           // Chance of a host idle gap per beat
    fifo_entry_t host_q[$];                         // Beats still to push into the DUT
    byte_t       exp_bytes[$];                      // Expected wire bytes, all frames
    frame_cnt_t  exp_len[$];                        // Expected wire length per frame
    byte_t       cur_frame[$];                      // Bytes of the frame now on the wire
    frame_cnt_t  gap_cnt;                           // Idle delivered cycles, saturating
    logic        seen_frame;                        // Gap counts only after a first frame
    int          frames_queued;
    int          frames_written;                    // Last beats accepted by the DUT
    int          frames_seen;
    int          byte_errs;
    int          count_errs;
    int          other_errs;

    eth_tx_top eth_tx_top_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .s_beat    (s_beat),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .phy_ready (phy_ready),
        .tx        (tx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reflected CRC-32, one bit at a time, LSB of each byte first
    function automatic crc_t crc32_ref(input byte_q_t bytes);
        crc_t c;
        logic fb;
        c = 32'hFFFF_FFFF;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ bytes[i][b];
                c  = c >> 1;
                if (fb) begin
                    c = c ^ 32'hEDB8_8320;
                end
            end
        end
        return ~c;
    endfunction

    // Whole wire image of one frame
    function automatic byte_q_t wire_ref(input byte_q_t frame);
        byte_q_t body;
        byte_q_t line_q;
        crc_t    fcs;
        body = frame;
        while (body.size() < `ETH_MIN_FRAME) begin
            body.push_back(8'h00);                  // Pad
        end
        fcs = crc32_ref(body);
        for (int i = 0; i < `ETH_PREAMBLE_LEN; i++) begin
            line_q.push_back(8'h55);
        end
        line_q.push_back(8'hD5);                    // SFD
        foreach (body[i]) begin
            line_q.push_back(body[i]);
        end
        for (int i = 0; i < 4; i++) begin
            line_q.push_back(fcs[8*i +: 8]);        // FCS low byte first
        end
        return line_q;
    endfunction

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            byte_errs++;
            $display("Fail %s exp %02h act %02h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_count(input string name, input frame_cnt_t exp,
                               input frame_cnt_t act, input bit at_least);
        if (at_least ? (act < exp) : (act !== exp)) begin
            count_errs++;
            $display("Fail %s exp %s%02h act %02h at %0t", name,
                     at_least ? ">=" : "", exp, act, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            other_errs++;
            $display("Fail %s exp %h act %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_crc(input string name, input crc_t exp, input crc_t act);
        if (act !== exp) begin
            other_errs++;
            $display("Fail %s exp %08h act %08h", name, exp, act);
        end
    endtask

    // Known answer for the reference CRC, ASCII 123456789
    task automatic crc_self_test();
        byte_q_t q;
        string   s;
        s = "123456789";
        for (int i = 0; i < s.len(); i++) begin
            q.push_back(byte_t'(s[i]));
        end
        check_crc("crc32_ref", 32'hCBF4_3926, crc32_ref(q));
    endtask

    // Random frame into host queue, its wire image into the expected queues
    task automatic add_frame(input int len);
        byte_q_t     frame;
        byte_q_t     line_q;
        fifo_entry_t b;
        for (int i = 0; i < len; i++) begin
            frame.push_back(byte_t'($urandom));
        end
        line_q = wire_ref(frame);
        foreach (line_q[i]) begin
            exp_bytes.push_back(line_q[i]);
        end
        exp_len.push_back(frame_cnt_t'(line_q.size()));
        frames_queued++;
        foreach (frame[i]) begin
            b.data = frame[i];
            b.last = (i == len - 1);
            host_q.push_back(b);
        end
    endtask

    // Called on a rising edge, returns on the edge of the final transfer
    task automatic send_queued();
        fifo_entry_t b;
        while (host_q.size() > 0) begin
            b = host_q.pop_front();
            if (($urandom % 100) < gap_pct) begin
                s_valid <= 1'b0;                    // Host idle for a few cycles
                repeat (1 + $urandom % 3) @(posedge clk);
            end
            s_beat  <= b;
            s_valid <= 1'b1;
            @(posedge clk);
            while (!s_ready) begin
                @(posedge clk);                     // Buffer full, hold the beat
            end
            if (b.last) begin
                frames_written++;
            end
        end
        s_valid <= 1'b0;
    endtask

    task automatic wait_frames();
        wait (frames_seen >= frames_queued);
        @(posedge clk);
        check_flag("s_ready", 1'b1, s_ready);       // Buffer drained, room again
    endtask

    task automatic drive_phy_ready();
        forever begin
            @(posedge clk);
            phy_ready <= stall_on ? (($urandom % 100) >= 30) : 1'b1;   // About 30% stalls
        end
    endtask

    task automatic watchdog();
        int wire_total;
        int limit_ns;
        wire_total = 0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            wire_total += 8 + ((FRAME_LEN[i] > 60) ? FRAME_LEN[i] : 60) + 4 + 16;
        end
        limit_ns = 2 * wire_total * CLK_PERIOD * 4;  // Headroom for stalls and host gaps
        #(limit_ns);
        $display("Timeout after %0d ns, only %0d of %0d frames came out",
                 limit_ns, frames_seen, frames_queued);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic frame_start_checks();
        if (seen_frame) begin
            check_count("ifg idle cycles", IFG_MIN, gap_cnt, 1'b1);
        end
        if (frames_written <= frames_seen) begin
            other_errs++;
            $display("Frame %0d started before its last byte was written", frames_seen);
        end
    endtask

    task automatic compare_frame();
        frame_cnt_t len;
        byte_t      exp_b;
        if (exp_len.size() == 0) begin
            other_errs++;
            $display("Unexpected extra frame of %0d bytes at %0t", cur_frame.size(), $time);
        end else begin
            len = exp_len.pop_front();
            check_count("frame length", len, frame_cnt_t'(cur_frame.size()), 1'b0);
            for (int i = 0; i < int'(len); i++) begin
                exp_b = exp_bytes.pop_front();
                if (i < cur_frame.size()) begin
                    check_byte("tx.data", exp_b, cur_frame[i]);
                end
            end
        end
        frames_seen++;
        cur_frame.delete();
    endtask

    // Monitor, only delivered cycles count
    always @(posedge clk) begin
        if (reset_n && phy_ready) begin
            if (tx.en) begin
                if (cur_frame.size() == 0) begin
                    frame_start_checks();
                end
                cur_frame.push_back(tx.data);
            end else begin
                if (cur_frame.size() > 0) begin   // tx.en fell, frame complete
                    compare_frame();
                    seen_frame = 1'b1;
                    gap_cnt    = '0;
                end
                if (gap_cnt != '1) begin
                    gap_cnt = gap_cnt + frame_cnt_t'(1);
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hc03e_647f));
        reset_n        = 1'b0;
        s_beat         = '0;
        s_valid        = 1'b0;
        phy_ready      = 1'b1;
        stall_on       = 1'b0;
        gap_pct        = 0;
        gap_cnt        = '0;
        seen_frame     = 1'b0;
        frames_queued  = 0;
        frames_written = 0;
        frames_seen    = 0;
        byte_errs      = 0;
        count_errs     = 0;
        other_errs     = 0;
        fork
            drive_phy_ready();
            watchdog();
        join_none
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        check_flag("s_ready", 1'b1, s_ready);       // Empty buffer out of reset
        crc_self_test();
        // Short frame with pad, then a long one without
        add_frame(FRAME_LEN[0]);
        send_queued();
        wait_frames();
        add_frame(FRAME_LEN[1]);
        send_queued();
        wait_frames();
        // Back to back, gap checked by the monitor
        for (int i = 2; i < 5; i++) begin
            add_frame(FRAME_LEN[i]);
        end
        send_queued();
        wait_frames();
        // PHY back-pressure
        stall_on = 1'b1;
        add_frame(FRAME_LEN[5]);
        add_frame(FRAME_LEN[6]);
        send_queued();
        wait_frames();
        // Host gaps while stalls let the buffer fill
        gap_pct = 20;
        add_frame(FRAME_LEN[7]);
        add_frame(FRAME_LEN[8]);
        send_queued();
        wait_frames();
        $display("Errors: %0d byte, %0d count, %0d other", byte_errs, count_errs, other_errs);
        if (byte_errs + count_errs + other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== eth_tx_top.f ====
+incdir+verilog
verilog/eth_tx_pkg.sv
verilog/eth_tx_fifo.sv
verilog/eth_crc32.sv
verilog/eth_tx_mac.sv
verilog/eth_tx_top.sv
dv/eth_tx_props.sv
dv/eth_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the Ethernet TX testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module eth_tx_tb \
    -f eth_tx_top.f \
    -o eth_tx_sim

./obj_dir/eth_tx_sim 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
